/* hw/rv_fetch_config.svh */
`ifndef RV_FETCH_CONFIG_SVH
`define RV_FETCH_CONFIG_SVH

// datapath and address width
`define XLEN 32

// fetch transaction id width
`define FETCH_ID_W 4

// boot address and sequential increment
`define RESET_PC 32'h8000_0000
`define PC_STEP  32'd4

`endif

/* hw/rv_fetch_pkg.sv */
`include "rv_fetch_config.svh"

package rv_fetch_pkg;

    typedef logic [`XLEN-1:0]       pc_t;        // instruction address
    typedef logic [`FETCH_ID_W-1:0] fetch_id_t;  // fetch transaction id

    // fetch round sequencer
    typedef enum logic [2:0] {
        F_IDLE      = 3'd0,
        F_PREP      = 3'd1,
        F_MEM       = 3'd2,  // waiting on memory result
        F_WB        = 3'd3,  // waiting on write-back result
        F_ISSUE     = 3'd4,
        F_WAIT_CORE = 3'd5,
        F_FINISH    = 3'd6
    } fetch_state_e;

    // mul/div retirement tracking
    typedef enum logic [1:0] {
        MD_IDLE       = 2'd0,
        MD_EXEC       = 2'd1,
        MD_WAIT_READY = 2'd2,  // done seen while core not ready
        MD_RETIRE     = 2'd3
    } md_state_e;

endpackage

/* hw/fetch_ctrl.sv */
module fetch_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   mem_pending,    // load/store still owns the bus
    input  logic                   mem_res_valid,
    input  logic                   wb_res_valid,
    input  logic                   wb_start,
    input  logic                   core_ready,
    output logic                   fetch_valid,
    output rv_fetch_pkg::fetch_id_t fetch_id,
    output logic                   fetch_en
);

    import rv_fetch_pkg::*;

    localparam fetch_id_t ISSUE_ID = fetch_id_t'(1);  // id carried by a real fetch

    fetch_state_e state;
    fetch_state_e state_next;

    // fetch enable comes up one edge after reset release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= F_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            F_IDLE: begin
                if (mem_pending) begin
                    state_next = F_MEM;
                end else begin
                    state_next = F_PREP;
                end
            end
            F_MEM: begin
                if (mem_res_valid) begin
                    state_next = F_WB;
                end
            end
            F_WB: begin
                if (wb_res_valid) begin
                    state_next = F_ISSUE;
                end
            end
            F_PREP: begin
                // a pending write-back goes ahead of the fetch
                if (wb_start) begin
                    state_next = F_WB;
                end else begin
                    state_next = F_ISSUE;
                end
            end
            F_ISSUE: begin
                if (mem_pending) begin
                    state_next = F_MEM;
                end else begin
                    state_next = F_WAIT_CORE;
                end
            end
            F_WAIT_CORE: begin
                if (core_ready) begin
                    state_next = F_FINISH;
                end
            end
            F_FINISH: begin
                state_next = F_IDLE;
            end
            default: begin
                state_next = F_IDLE;
            end
        endcase
    end

    // strobe and id are registered copies of the state decode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_valid <= 1'b0;
            fetch_id    <= '0;
        end else begin
            case (state)
                F_ISSUE: begin
                    fetch_valid <= 1'b1;   // one pulse per round
                    fetch_id    <= ISSUE_ID;
                end
                F_WAIT_CORE: begin
                    fetch_valid <= 1'b0;
                    fetch_id    <= ISSUE_ID;  // id stays up while core stalls
                end
                default: begin
                    fetch_valid <= 1'b0;
                    fetch_id    <= '0;
                end
            endcase
        end
    end

endmodule

/* hw/md_stall_tracker.sv */
module md_stall_tracker (
    input  logic clk,
    input  logic rst_n,
    input  logic mul_busy,
    input  logic div_busy,
    input  logic mul_done,    // one cycle
    input  logic div_done,    // one cycle
    input  logic core_ready,
    input  logic redirect,
    output logic md_hold,
    output logic md_advance
);

    import rv_fetch_pkg::*;

    md_state_e state;
    md_state_e state_next;

    logic busy;
    logic done;

    assign busy = mul_busy | div_busy;
    assign done = mul_done | div_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= MD_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            MD_IDLE: begin
                if (busy) begin
                    state_next = MD_EXEC;
                end
            end
            MD_EXEC: begin
                if (done && core_ready) begin
                    state_next = MD_RETIRE;
                end else if (done) begin
                    state_next = MD_WAIT_READY;
                end
            end
            MD_WAIT_READY: begin
                if (core_ready) begin
                    state_next = MD_RETIRE;
                end
            end
            MD_RETIRE: begin
                state_next = MD_IDLE;
            end
            default: begin
                state_next = MD_IDLE;
            end
        endcase
    end

    // busy covers the issue cycle before the state catches up
    assign md_hold = busy || (state == MD_EXEC) || (state == MD_WAIT_READY);

    // a same-cycle redirect takes over the pc instead
    assign md_advance = (state == MD_RETIRE) && !redirect;

endmodule

/* hw/pc_reg.sv */
`include "rv_fetch_config.svh"

module pc_reg (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              md_hold,      // mul/div in flight
    input  logic              md_advance,   // mul/div retires
    input  logic              mem_hold,
    input  logic              jalr_stall,
    input  logic              redirect,
    input  logic              core_ready,
    input  rv_fetch_pkg::pc_t redirect_pc,
    output rv_fetch_pkg::pc_t curr_pc
);

    import rv_fetch_pkg::*;

    logic jalr_q;      // jalr target is due this edge
    logic redirect_q;  // blocks the step right after a redirect
    pc_t  pc_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            jalr_q     <= 1'b0;
            redirect_q <= 1'b0;
        end else begin
            jalr_q     <= jalr_stall;
            redirect_q <= redirect;
        end
    end

    // priority order matters here
    always_comb begin
        if (md_advance) begin
            pc_next = curr_pc + `PC_STEP;
        end else if (md_hold) begin
            pc_next = curr_pc;
        end else if (mem_hold) begin
            pc_next = curr_pc;
        end else if (jalr_stall) begin
            pc_next = curr_pc;           // target not resolved yet
        end else if (jalr_q) begin
            pc_next = redirect_pc;
        end else if (redirect) begin
            pc_next = redirect_pc;
        end else if (core_ready && !redirect_q) begin
            pc_next = curr_pc + `PC_STEP;
        end else begin
            pc_next = curr_pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            curr_pc <= `RESET_PC;  // boot vector
        end else begin
            curr_pc <= pc_next;
        end
    end

endmodule

/* hw/fetch_unit_top.sv */
module fetch_unit_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    redirect,
    input  rv_fetch_pkg::pc_t       redirect_pc,
    input  logic                    jalr_stall,
    input  logic                    mem_hold,
    input  logic                    mul_busy,
    input  logic                    div_busy,
    input  logic                    mul_done,
    input  logic                    div_done,
    input  logic                    core_ready,
    input  logic                    mem_pending,
    input  logic                    mem_res_valid,
    input  logic                    wb_res_valid,
    input  logic                    wb_start,
    output rv_fetch_pkg::pc_t       curr_pc,
    output logic                    fetch_valid,
    output rv_fetch_pkg::fetch_id_t fetch_id,
    output logic                    fetch_en
);

    // mul/div control into the pc
    logic md_hold;
    logic md_advance;

    fetch_ctrl u_fetch_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_pending   (mem_pending),
        .mem_res_valid (mem_res_valid),
        .wb_res_valid  (wb_res_valid),
        .wb_start      (wb_start),
        .core_ready    (core_ready),
        .fetch_valid   (fetch_valid),
        .fetch_id      (fetch_id),
        .fetch_en      (fetch_en)
    );

    md_stall_tracker u_md_stall_tracker (
        .clk        (clk),
        .rst_n      (rst_n),
        .mul_busy   (mul_busy),
        .div_busy   (div_busy),
        .mul_done   (mul_done),
        .div_done   (div_done),
        .core_ready (core_ready),
        .redirect   (redirect),
        .md_hold    (md_hold),
        .md_advance (md_advance)
    );

    pc_reg u_pc_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .md_hold     (md_hold),
        .md_advance  (md_advance),
        .mem_hold    (mem_hold),
        .jalr_stall  (jalr_stall),
        .redirect    (redirect),
        .core_ready  (core_ready),
        .redirect_pc (redirect_pc),
        .curr_pc     (curr_pc)
    );

endmodule

/* bench/fetch_unit_chk.sv */
`include "rv_fetch_config.svh"

module fetch_unit_chk (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    redirect,
    input logic                    jalr_stall,
    input rv_fetch_pkg::pc_t       curr_pc,
    input logic                    fetch_valid,
    input rv_fetch_pkg::fetch_id_t fetch_id,
    input logic                    fetch_en
);
    timeunit 1ns;
    timeprecision 1ps;

    import rv_fetch_pkg::*;

    // one strobe per round and never back to back
    valid_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_valid |=> !fetch_valid)
        else $error("fetch_valid high on two consecutive cycles");

    valid_carries_id: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_valid |-> fetch_id == fetch_id_t'(1))
        else $error("fetch_valid without fetch_id 1");

    // without a redirect or a due jalr load, any pc change is a plain step
    pc_change_is_step: assert property (@(posedge clk) disable iff (!rst_n)
        (curr_pc != $past(curr_pc)) && !$past(redirect) && !$past(jalr_stall, 2)
        |-> curr_pc == $past(curr_pc) + `PC_STEP)
        else $error("pc changed by something other than one step");

    fetch_en_stays_up: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_en |=> fetch_en)
        else $error("fetch_en dropped after it rose");

endmodule

bind fetch_unit_top fetch_unit_chk u_fetch_unit_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .redirect    (redirect),
    .jalr_stall  (jalr_stall),
    .curr_pc     (curr_pc),
    .fetch_valid (fetch_valid),
    .fetch_id    (fetch_id),
    .fetch_en    (fetch_en)
);

/* bench/fetch_unit_tb.sv */
`include "rv_fetch_config.svh"

module fetch_unit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_fetch_pkg::*;

    localparam int MAX_CYCLES = 2000;  // well above the directed sequence length

    logic      clk = 1'b0;
    logic      rst_n;
    logic      redirect;
    pc_t       redirect_pc;
    logic      jalr_stall;
    logic      mem_hold;
    logic      mul_busy;
    logic      div_busy;
    logic      mul_done;
    logic      div_done;
    logic      core_ready;
    logic      mem_pending;
    logic      mem_res_valid;
    logic      wb_res_valid;
    logic      wb_start;
    pc_t       curr_pc;
    logic      fetch_valid;
    fetch_id_t fetch_id;
    logic      fetch_en;

    int  mismatch_count = 0;
    int  other_count = 0;
    int  cycle_count = 0;
    pc_t exp_pc;  // model of the program counter

    fetch_unit_top uut (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            other_count++;
            $display("error: timeout, run still going after %0d cycles", MAX_CYCLES);
            report_and_finish();
        end
    end

    task automatic check_pc(input pc_t got, input pc_t exp, input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t: %s, expected %h, got %h", $time, what, exp, got);
        end
    endtask

    task automatic check_id(input fetch_id_t got, input fetch_id_t exp, input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t: %s, expected %0d, got %0d", $time, what, exp, got);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t: %s, expected %b, got %b", $time, what, exp, got);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            mismatch_count++;
            $display("mismatch at %0t: %s, expected %0d, got %0d", $time, what, exp, got);
        end
    endtask

    task automatic report_and_finish();
        $display("summary: %0d mismatches, %0d other errors", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    endtask

    task automatic clear_inputs();
        redirect      <= 1'b0;
        redirect_pc   <= '0;
        jalr_stall    <= 1'b0;
        mem_hold      <= 1'b0;
        mul_busy      <= 1'b0;
        div_busy      <= 1'b0;
        mul_done      <= 1'b0;
        div_done      <= 1'b0;
        core_ready    <= 1'b0;
        mem_pending   <= 1'b0;
        mem_res_valid <= 1'b0;
        wb_res_valid  <= 1'b0;
        wb_start      <= 1'b0;
    endtask

    // n edges over which the pc must not move
    task automatic hold_cycles(input int n, input string what);
        repeat (n) begin
            @(posedge clk);
            @(negedge clk);
            check_pc(curr_pc, exp_pc, what);
        end
    endtask

    task automatic drive_md(input bit use_div, input logic busy, input logic done);
        mul_busy <= busy & ~use_div;
        div_busy <= busy & use_div;
        mul_done <= done & ~use_div;
        div_done <= done & use_div;
    endtask

    task automatic count_pulses(input int cycles, output int n);
        n = 0;
        repeat (cycles) begin
            @(posedge clk);
            @(negedge clk);
            if (fetch_valid === 1'b1) begin
                n++;
                check_id(fetch_id, fetch_id_t'(1), "id on fetch pulse");
            end
        end
    endtask

    task automatic wait_fetch_pulse(input int limit);
        int waited;
        waited = 0;
        @(negedge clk);
        while (fetch_valid !== 1'b1 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (fetch_valid !== 1'b1) begin
            other_count++;
            $display("error: no fetch_valid pulse within %0d cycles", limit);
        end
    endtask

    task automatic test_reset();
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            if (i == 4) begin
                rst_n <= 1'b1;  // this edge still sees reset
            end
            @(negedge clk);
            check_pc(curr_pc, `RESET_PC, "pc in reset");
            check_bit(fetch_valid, 1'b0, "fetch_valid in reset");
            check_id(fetch_id, '0, "fetch_id in reset");
            check_bit(fetch_en, 1'b0, "fetch_en in reset");
        end
        for (int i = 0; i < 2; i++) begin
            @(posedge clk);
            @(negedge clk);
            check_pc(curr_pc, `RESET_PC, "pc after reset");
            check_bit(fetch_valid, 1'b0, "fetch_valid after reset");
            check_bit(fetch_en, 1'b1, "fetch_en after reset");
        end
        exp_pc = `RESET_PC;
    endtask

    task automatic test_sequential();
        int steps;
        steps = 3 + int'($urandom % 8);
        @(posedge clk);
        core_ready <= 1'b1;
        for (int i = 0; i < steps; i++) begin
            @(posedge clk);
            if (i == steps - 1) begin
                core_ready <= 1'b0;
            end
            @(negedge clk);
            exp_pc = exp_pc + `PC_STEP;
            check_pc(curr_pc, exp_pc, "sequential step");
        end
        hold_cycles(3, "pc held without core_ready");
        @(posedge clk);
        core_ready <= 1'b1;
        mem_hold   <= 1'b1;
        hold_cycles(4, "pc held by mem_hold");
        @(posedge clk);
        core_ready <= 1'b0;
        mem_hold   <= 1'b0;
        @(negedge clk);
        check_pc(curr_pc, exp_pc, "pc held by mem_hold");
        hold_cycles(2, "pc idle after mem_hold");
    endtask

    task automatic test_redirect();
        pc_t target;
        target = pc_t'($urandom) & ~pc_t'(3);  // word aligned
        @(posedge clk);
        redirect    <= 1'b1;
        redirect_pc <= target;
        core_ready  <= 1'b1;
        @(posedge clk);
        redirect <= 1'b0;
        @(negedge clk);
        exp_pc = target;
        check_pc(curr_pc, exp_pc, "redirect target loaded");
        hold_cycles(1, "no step right after redirect");
        @(posedge clk);
        core_ready <= 1'b0;
        @(negedge clk);
        exp_pc = exp_pc + `PC_STEP;
        check_pc(curr_pc, exp_pc, "step resumes after redirect");

        // jump-register target loads one edge after the stall
        target = pc_t'($urandom) & ~pc_t'(3);
        @(posedge clk);
        jalr_stall  <= 1'b1;
        redirect_pc <= target;
        core_ready  <= 1'b1;
        @(posedge clk);
        jalr_stall <= 1'b0;
        core_ready <= 1'b0;
        @(negedge clk);
        check_pc(curr_pc, exp_pc, "pc held by jalr_stall");
        @(posedge clk);
        @(negedge clk);
        exp_pc = target;
        check_pc(curr_pc, exp_pc, "jalr target loaded");
        hold_cycles(2, "pc idle after jalr");
    endtask

    task automatic run_md_op(input bit use_div, input bit late_ready, input string name);
        @(posedge clk);
        core_ready <= 1'b1;  // ready high to show the hold wins
        drive_md(use_div, 1'b1, 1'b0);
        hold_cycles(3, {name, " held while busy"});
        @(posedge clk);
        drive_md(use_div, 1'b0, 1'b1);
        if (late_ready) begin
            core_ready <= 1'b0;
        end
        @(negedge clk);
        check_pc(curr_pc, exp_pc, {name, " held on last busy edge"});
        @(posedge clk);
        drive_md(use_div, 1'b0, 1'b0);
        core_ready <= 1'b0;
        @(negedge clk);
        check_pc(curr_pc, exp_pc, {name, " held on done edge"});
        if (late_ready) begin
            hold_cycles(3, {name, " held until core_ready"});
            @(posedge clk);
            core_ready <= 1'b1;
            @(negedge clk);
            check_pc(curr_pc, exp_pc, {name, " held until core_ready"});
            @(posedge clk);
            core_ready <= 1'b0;
            @(negedge clk);
            check_pc(curr_pc, exp_pc, {name, " held on core_ready edge"});
        end
        @(posedge clk);
        @(negedge clk);
        exp_pc = exp_pc + `PC_STEP;
        check_pc(curr_pc, exp_pc, {name, " retire step"});
        hold_cycles(2, {name, " idle after retire"});
    endtask

    task automatic test_muldiv();
        run_md_op(1'b0, 1'b0, "mul");
        run_md_op(1'b1, 1'b0, "div");
        run_md_op(1'b0, 1'b1, "mul with late ready");
        run_md_op(1'b1, 1'b1, "div with late ready");
    endtask

    task automatic test_fetch_rounds();
        int pulses;
        int rounds;
        rounds = 4;
        // kick the sequencer so it ends up waiting for core_ready
        @(posedge clk);
        core_ready <= 1'b1;
        @(posedge clk);
        core_ready <= 1'b0;
        wait_fetch_pulse(20);
        check_id(fetch_id, fetch_id_t'(1), "id on fetch pulse");
        pulses = 0;
        for (int r = 0; r < rounds; r++) begin
            for (int c = 0; c < 8; c++) begin
                @(posedge clk);
                core_ready <= (c == 0);  // one ready pulse per round
                @(negedge clk);
                if (fetch_valid === 1'b1) begin
                    pulses++;
                    check_id(fetch_id, fetch_id_t'(1), "id on fetch pulse");
                end
            end
        end
        check_count(pulses, rounds, "fetch pulses, one per round");
        check_id(fetch_id, fetch_id_t'(1), "id while waiting for core_ready");

        @(posedge clk);
        mem_pending <= 1'b1;
        core_ready  <= 1'b1;
        @(posedge clk);
        core_ready <= 1'b0;
        count_pulses(20, pulses);
        check_count(pulses, 0, "fetch pulses without memory result");
        @(posedge clk);
        mem_res_valid <= 1'b1;
        mem_pending   <= 1'b0;
        @(posedge clk);
        mem_res_valid <= 1'b0;
        count_pulses(4, pulses);
        check_count(pulses, 0, "fetch pulses before write-back result");
        @(posedge clk);
        wb_res_valid <= 1'b1;
        @(posedge clk);
        wb_res_valid <= 1'b0;
        count_pulses(10, pulses);
        check_count(pulses, 1, "fetch pulses after memory and write-back results");
        check_id(fetch_id, fetch_id_t'(1), "id while waiting for core_ready");
    endtask

    initial begin
        void'($urandom(66));
        rst_n <= 1'b0;
        clear_inputs();
        test_reset();
        test_sequential();
        test_redirect();
        test_muldiv();
        test_fetch_rounds();
        report_and_finish();
    end

endmodule

/* filelist.f */
+incdir+hw
hw/rv_fetch_pkg.sv
hw/fetch_ctrl.sv
hw/md_stall_tracker.sv
hw/pc_reg.sv
hw/fetch_unit_top.sv
bench/fetch_unit_chk.sv
bench/fetch_unit_tb.sv

/* Makefile */
SRCS := $(shell grep -v '^+' filelist.f)

.PHONY: all run clean

all: run

obj_dir/Vfetch_unit_tb: filelist.f hw/rv_fetch_config.svh $(SRCS)
	verilator --binary --timing --assert --top-module fetch_unit_tb -f filelist.f

run: obj_dir/Vfetch_unit_tb
	./obj_dir/Vfetch_unit_tb > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Done: errors found" sim.log; then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "Done: no errors" sim.log; then \
		echo "simulation stopped without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
